//--- rtl/cart_macros.svh
// Cartridge loader widths

`ifndef CART_MACROS_SVH
`define CART_MACROS_SVH

// Download stream
`define CART_ADDR_W       25    // Byte address from the loader
`define CART_DATA_W       16    // One word per write

// Console side address
`define CART_VA_HI        23    // Top bit of the word address
`define CART_MASK_LO      13    // Size mask covers 8 KB granules and up

// Bank mapper
`define CART_BANK_W       5     // 512 KB banks, 16 MB reach
`define CART_NUM_BANKS    8

// Region change settle window, counter width
`define CART_SETTLE_BITS  16

`endif

//--- rtl/loader_pkg.sv
// Download stream constants

`default_nettype none

`include "cart_macros.svh"

package loader_pkg;

	////////////////////////////////////////
	// Stream index decode
	////////////////////////////////////////

	// Indexes 0 and 1 carry ROM images, compared on bits 5..0
	localparam logic [5:0] rom_index_max = 6'h01;

	// Set for a cartridge image, clear for a BIOS image
	localparam int cart_flag_bit = 6;

	////////////////////////////////////////
	// Cartridge header
	////////////////////////////////////////

	localparam logic [`CART_ADDR_W-1:0] hdr_region_addr = 'h1F0;   // Region letter word

	localparam logic [7:0] region_char_jp = "J";
	localparam logic [7:0] region_char_us = "U";   // Anything else means EU

endpackage

`default_nettype wire

//--- rtl/cart_map_pkg.sv
// Cartridge mapping types

`default_nettype none

`include "cart_macros.svh"

package cart_map_pkg;

	// Console region, bit 1 doubles as the PAL flag
	typedef enum logic [1:0] {
		region_jp = 2'd0,
		region_us = 2'd1,
		region_eu = 2'd2
	} region_t;

	// One 512 KB bank number
	typedef logic [`CART_BANK_W-1:0] bank_t;

	////////////////////////////////////////
	// Mapper address fields
	////////////////////////////////////////

	// Register select on a page write
	localparam int page_sel_hi = 3;
	localparam int page_sel_lo = 1;

	// Bank select on a ROM read
	localparam int bank_sel_hi = 21;
	localparam int bank_sel_lo = 19;

	// Mask bits 23..22, any of them set means an image above 4 MB
	localparam logic [`CART_VA_HI:`CART_MASK_LO] big_rom_bits = 11'b110_0000_0000;

endpackage

`default_nettype wire

//--- rtl/download_tracker.sv
// Download stream tracker

`timescale 1ns/100ps
`default_nettype none

`include "cart_macros.svh"

module download_tracker (
	input  wire                              clk_sys,
	input  wire                              reset,

	// Loader stream
	input  wire                              ioctl_download,
	input  wire [7:0]                        ioctl_index,
	input  wire                              ioctl_wr,
	input  wire [`CART_ADDR_W-1:0]           ioctl_addr,
	input  wire [`CART_DATA_W-1:0]           ioctl_data,

	output logic                             rom_download,
	output logic                             rom_cart_mode,
	output logic [`CART_VA_HI:`CART_MASK_LO] rom_mask,
	output cart_map_pkg::region_t            region_req
);

	logic rom_wr;
	logic cart_img;
	logic hdr_hit;

	////////////////////////////////////////
	// Stream decode
	////////////////////////////////////////

	// Index 0/1 is ROM, higher indexes belong to other loaders
	assign rom_download = ioctl_download & (ioctl_index[5:0] <= loader_pkg::rom_index_max);

	assign rom_wr   = rom_download & ioctl_wr;
	assign cart_img = ioctl_index[loader_pkg::cart_flag_bit];
	assign hdr_hit  = (ioctl_addr == loader_pkg::hdr_region_addr);

	////////////////////////////////////////
	// Cartridge mode and size mask
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_cart_mode <= 1'b0;
			rom_mask      <= '0;
		end else if (rom_wr) begin
			rom_cart_mode <= cart_img;    // Last ROM write wins
			if (cart_img) begin
				// First word of a new image restarts the mask
				if (ioctl_addr == '0)
					rom_mask <= '0;
				else
					rom_mask <= rom_mask | ioctl_addr[`CART_VA_HI:`CART_MASK_LO];
			end
		end
	end

	////////////////////////////////////////
	// Header region letter
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			region_req <= cart_map_pkg::region_jp;
		end else if (rom_wr && hdr_hit) begin
			// Only the low byte of the header word matters
			if (ioctl_data[7:0] == loader_pkg::region_char_jp)
				region_req <= cart_map_pkg::region_jp;
			else if (ioctl_data[7:0] == loader_pkg::region_char_us)
				region_req <= cart_map_pkg::region_us;
			else
				region_req <= cart_map_pkg::region_eu;
		end
	end

endmodule

`default_nettype wire

//--- rtl/region_ctrl.sv
// Region select and settle timer

`timescale 1ns/100ps
`default_nettype none

`include "cart_macros.svh"

module region_ctrl #(
	parameter int settle_bits = `CART_SETTLE_BITS
) (
	input  wire                          clk_sys,
	input  wire                          reset,
	input  cart_map_pkg::region_t        region_req,
	input  wire [1:0]                    region_override,  // 0 = auto from header
	output cart_map_pkg::region_t        region,
	output logic                         region_set
);

	cart_map_pkg::region_t    region_new;
	logic [settle_bits-1:0]   settle_cnt;

	// Operator override is offset by one, zero leaves the header choice
	always_comb begin
		if (region_override != 2'd0)
			region_new = cart_map_pkg::region_t'(region_override - 2'd1);
		else
			region_new = region_req;
	end

	////////////////////////////////////////
	// Active region and settle window
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			region     <= cart_map_pkg::region_jp;
			settle_cnt <= '0;     // Window runs again out of reset
			region_set <= 1'b0;
		end else begin
			region <= region_new;

			// Saturating count, high until all ones
			region_set <= 1'b0;
			if (~&settle_cnt) begin
				settle_cnt <= settle_cnt + 1'b1;
				region_set <= 1'b1;
			end

			// Any change restarts the window from zero
			if (region != region_new)
				settle_cnt <= '0;
		end
	end

endmodule

`default_nettype wire

//--- rtl/bank_mapper.sv
// Large ROM bank mapper

`timescale 1ns/100ps
`default_nettype none

`include "cart_macros.svh"

module bank_mapper (
	input  wire                             clk_sys,
	input  wire                             reset,
	input  wire                             rom_download,
	input  wire [`CART_VA_HI:`CART_MASK_LO] rom_mask,

	// Console bus
	input  wire [`CART_VA_HI:1]             gen_va,
	input  wire [`CART_DATA_W-1:0]          gen_vdo,
	input  wire                             gen_rnw,
	input  wire                             page_ce_n,

	output logic [`CART_VA_HI:1]            rom_va
);

	cart_map_pkg::bank_t  bank_regs [`CART_NUM_BANKS];
	logic                 page_ce_q;
	logic                 page_fall;
	logic [2:0]           page_sel;
	logic                 big_rom;
	logic                 bank_wr;

	////////////////////////////////////////
	// Page strobe decode
	////////////////////////////////////////

	assign page_fall = page_ce_q & ~page_ce_n;
	assign page_sel  = gen_va[cart_map_pkg::page_sel_hi:cart_map_pkg::page_sel_lo];
	assign big_rom   = |(rom_mask & cart_map_pkg::big_rom_bits);

	// Register 0 is fixed, images up to 4 MB never bank
	assign bank_wr = page_fall & ~gen_rnw & (page_sel != 3'd0) & big_rom;

	always_ff @(posedge clk_sys) begin
		if (reset)
			page_ce_q <= 1'b1;
		else
			page_ce_q <= page_ce_n;
	end

	////////////////////////////////////////
	// Bank registers
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset || rom_download) begin
			// Identity map, bank n at slot n
			for (int i = 0; i < `CART_NUM_BANKS; i++)
				bank_regs[i] <= cart_map_pkg::bank_t'(i);
		end else if (bank_wr) begin
			bank_regs[page_sel] <= gen_vdo[`CART_BANK_W-1:0];
		end
	end

	////////////////////////////////////////
	// ROM address
	////////////////////////////////////////

	// Bank from the top address bits, masked to the loaded image size
	assign rom_va = {bank_regs[gen_va[cart_map_pkg::bank_sel_hi:cart_map_pkg::bank_sel_lo]],
	                 gen_va[cart_map_pkg::bank_sel_lo-1:1]}
	              & {rom_mask, {(`CART_MASK_LO-1){1'b1}}};

endmodule

`default_nettype wire

//--- rtl/cart_loader_top.sv
// Cartridge loader top level

`timescale 1ns/100ps
`default_nettype none

`include "cart_macros.svh"

module cart_loader_top #(
	parameter int settle_bits = `CART_SETTLE_BITS
) (
	input  wire                    clk_sys,
	input  wire                    reset,

	// Loader stream
	input  wire                    ioctl_download,
	input  wire [7:0]              ioctl_index,
	input  wire                    ioctl_wr,
	input  wire [`CART_ADDR_W-1:0] ioctl_addr,
	input  wire [`CART_DATA_W-1:0] ioctl_data,

	// Operator menu, 0 = auto
	input  wire [1:0]              region_override,

	// Console bus
	input  wire [`CART_VA_HI:1]    gen_va,
	input  wire [`CART_DATA_W-1:0] gen_vdo,
	input  wire                    gen_rnw,
	input  wire                    page_ce_n,

	output wire                    rom_download,
	output wire                    rom_cart_mode,
	output cart_map_pkg::region_t  region,
	output wire                    region_set,
	output wire [`CART_VA_HI:1]    rom_va
);

	wire [`CART_VA_HI:`CART_MASK_LO] rom_mask;
	cart_map_pkg::region_t           region_req;

	////////////////////////////////////////
	// Download side
	////////////////////////////////////////

	download_tracker u_download_tracker (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_data     (ioctl_data),
		.rom_download   (rom_download),
		.rom_cart_mode  (rom_cart_mode),
		.rom_mask       (rom_mask),
		.region_req     (region_req)
	);

	region_ctrl #(
		.settle_bits (settle_bits)
	) u_region_ctrl (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.region_req      (region_req),
		.region_override (region_override),
		.region          (region),
		.region_set      (region_set)
	);

	////////////////////////////////////////
	// Console side
	////////////////////////////////////////

	bank_mapper u_bank_mapper (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.rom_download (rom_download),   // Fresh image means identity banks
		.rom_mask     (rom_mask),
		.gen_va       (gen_va),
		.gen_vdo      (gen_vdo),
		.gen_rnw      (gen_rnw),
		.page_ce_n    (page_ce_n),
		.rom_va       (rom_va)
	);

endmodule

`default_nettype wire

//--- test/cart_checker.sv
// Cartridge loader output checker

`timescale 1ns/100ps
`default_nettype none

module cart_checker (
	input  wire        clk_sys,
	input  wire        chk_probe,
	input  wire        chk_dl,
	input  wire        chk_settle,
	input  wire [23:1] exp_va,
	input  wire [1:0]  exp_region,
	input  wire        exp_cart,
	input  wire        exp_dl,
	input  wire [15:0] exp_run,

	// DUT outputs
	input  wire        rom_download,
	input  wire        rom_cart_mode,
	input  wire [1:0]  region,
	input  wire        region_set,
	input  wire [23:1] rom_va,

	output int         pass_count,
	output int         fail_count
);

	int test_num;
	int run_len;
	int last_run;

	initial begin
		pass_count = 0;
		fail_count = 0;
		test_num   = 0;
		run_len    = 0;
		last_run   = 0;
	end

	task automatic compare(input string name, input logic [31:0] got,
	                       input logic [31:0] exp, inout bit ok);
		if (got !== exp) begin
			$display("[FAIL] test %0d %s got %h expected %h", test_num, name, got, exp);
			ok = 1'b0;
		end
	endtask

	task automatic finish_test(input string what, input bit ok);
		if (ok) begin
			pass_count++;
			$display("[PASS] test %0d %s", test_num, what);
		end else begin
			fail_count++;
		end
	endtask

	////////////////////////////////////////
	// Sampled mid cycle away from the edges
	////////////////////////////////////////

	always @(negedge clk_sys) begin
		bit ok;

		// Length of each high stretch of region_set
		if (region_set) begin
			run_len = run_len + 1;
		end else if (run_len != 0) begin
			last_run = run_len;
			run_len  = 0;
		end

		if (chk_dl) begin
			test_num++;
			ok = 1'b1;
			compare("rom_download", 32'(rom_download), 32'(exp_dl), ok);
			finish_test("download decode", ok);
		end

		if (chk_probe) begin
			test_num++;
			ok = 1'b1;
			compare("rom_va", 32'(rom_va), 32'(exp_va), ok);
			compare("region", 32'(region), 32'(exp_region), ok);
			compare("rom_cart_mode", 32'(rom_cart_mode), 32'(exp_cart), ok);
			finish_test("address probe", ok);
		end

		if (chk_settle) begin
			test_num++;
			ok = 1'b1;
			compare("region_set run", 32'(last_run), 32'(exp_run), ok);
			finish_test("settle window", ok);
			last_run = 0;    // Each window is counted once
		end
	end

endmodule

`default_nettype wire

//--- test/tb_top.sv
// Cartridge loader testbench

`timescale 1ns/100ps
`default_nettype none

module tb_top;

	localparam int max_recs = 128;
	localparam int rec_words = 5;

	logic        clk_sys;
	logic        reset;
	logic        ioctl_download;
	logic [7:0]  ioctl_index;
	logic        ioctl_wr;
	logic [24:0] ioctl_addr;
	logic [15:0] ioctl_data;
	logic [1:0]  region_override;
	logic [23:1] gen_va;
	logic [15:0] gen_vdo;
	logic        gen_rnw;
	logic        page_ce_n;

	wire         rom_download;
	wire         rom_cart_mode;
	wire  [1:0]  region;
	wire         region_set;
	wire  [23:1] rom_va;

	// Expectations handed to the checker
	logic        chk_probe;
	logic        chk_dl;
	logic        chk_settle;
	logic [23:1] exp_va;
	logic [1:0]  exp_region;
	logic        exp_cart;
	logic        exp_dl;
	logic [15:0] exp_run;
	int          pass_count;
	int          fail_count;

	logic [31:0] script [0:max_recs*rec_words-1];
	int          cycle_count;
	int          cycle_limit;
	bit          bad_cmd;

	cart_loader_top #(
		.settle_bits (6)
	) u_cart_loader_top (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.ioctl_download  (ioctl_download),
		.ioctl_index     (ioctl_index),
		.ioctl_wr        (ioctl_wr),
		.ioctl_addr      (ioctl_addr),
		.ioctl_data      (ioctl_data),
		.region_override (region_override),
		.gen_va          (gen_va),
		.gen_vdo         (gen_vdo),
		.gen_rnw         (gen_rnw),
		.page_ce_n       (page_ce_n),
		.rom_download    (rom_download),
		.rom_cart_mode   (rom_cart_mode),
		.region          (region),
		.region_set      (region_set),
		.rom_va          (rom_va)
	);

	cart_checker u_cart_checker (
		.clk_sys       (clk_sys),
		.chk_probe     (chk_probe),
		.chk_dl        (chk_dl),
		.chk_settle    (chk_settle),
		.exp_va        (exp_va),
		.exp_region    (exp_region),
		.exp_cart      (exp_cart),
		.exp_dl        (exp_dl),
		.exp_run       (exp_run),
		.rom_download  (rom_download),
		.rom_cart_mode (rom_cart_mode),
		.region        (region),
		.region_set    (region_set),
		.rom_va        (rom_va),
		.pass_count    (pass_count),
		.fail_count    (fail_count)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	////////////////////////////////////////
	// Timeout
	////////////////////////////////////////

	initial cycle_count = 0;

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
			$display("Run stopped, no progress after %0d cycles", cycle_count);
			$display("TEST FAILED");
			$finish;
		end
	end

	////////////////////////////////////////
	// Stimulus tasks entered 1 ns after an edge
	////////////////////////////////////////

	task automatic load_word(input logic [7:0] idx, input logic [24:0] addr,
	                         input logic [15:0] data, input logic dl);
		ioctl_download = 1'b1;
		ioctl_index    = idx;
		ioctl_addr     = addr;
		ioctl_data     = data;
		ioctl_wr       = 1'b1;
		exp_dl         = dl;
		chk_dl         = 1'b1;
		@(posedge clk_sys);
		#1;
		ioctl_wr       = 1'b0;
		ioctl_download = 1'b0;
		chk_dl         = 1'b0;
	endtask

	task automatic page_write(input logic [2:0] sel, input logic [15:0] data);
		gen_va    = {20'd0, sel};    // Register number on bits 3..1
		gen_vdo   = data;
		gen_rnw   = 1'b0;
		page_ce_n = 1'b0;
		@(posedge clk_sys);
		#1;
		page_ce_n = 1'b1;
		gen_rnw   = 1'b1;
		@(posedge clk_sys);
		#1;
	endtask

	task automatic probe_addr(input logic [23:1] va, input logic [23:1] eva,
	                          input logic [1:0] ereg, input logic ecart);
		gen_va     = va;
		exp_va     = eva;
		exp_region = ereg;
		exp_cart   = ecart;
		@(posedge clk_sys);
		#1;
		chk_probe = 1'b1;
		@(posedge clk_sys);
		#1;
		chk_probe = 1'b0;
	endtask

	// Let the current window run out, then have its length checked
	task automatic settle_check(input logic [15:0] run);
		@(posedge clk_sys);
		#1;
		while (region_set) begin
			@(posedge clk_sys);
			#1;
		end
		@(posedge clk_sys);
		#1;
		exp_run    = run;
		chk_settle = 1'b1;
		@(posedge clk_sys);
		#1;
		chk_settle = 1'b0;
	endtask

	////////////////////////////////////////
	// Script runner
	////////////////////////////////////////

	initial begin
		int pc;
		logic [31:0] cmd;

		for (int i = 0; i < max_recs*rec_words; i++)
			script[i] = '0;
		$readmemh("test/cart_input.dat", script);

		// 16 cycles per data record plus waits and settle windows
		cycle_limit = 32;
		for (int i = 0; i < max_recs*rec_words && script[i] != 32'd0; i += rec_words) begin
			cycle_limit += 16;
			if (script[i] == 32'd5)
				cycle_limit += int'(script[i+1]);
			if (script[i] == 32'd6)
				cycle_limit += 64;
		end

		reset           = 1'b1;
		ioctl_download  = 1'b0;
		ioctl_index     = '0;
		ioctl_wr        = 1'b0;
		ioctl_addr      = '0;
		ioctl_data      = '0;
		region_override = 2'd0;
		gen_va          = '0;
		gen_vdo         = '0;
		gen_rnw         = 1'b1;
		page_ce_n       = 1'b1;
		chk_probe       = 1'b0;
		chk_dl          = 1'b0;
		chk_settle      = 1'b0;
		exp_va          = '0;
		exp_region      = '0;
		exp_cart        = 1'b0;
		exp_dl          = 1'b0;
		exp_run         = '0;
		bad_cmd         = 1'b0;

		repeat (2) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		pc = 0;
		while (pc < max_recs*rec_words && script[pc] != 32'd0) begin
			cmd = script[pc];
			case (cmd)
				32'd1: load_word(script[pc+1][7:0], script[pc+2][24:0],
				                 script[pc+3][15:0], script[pc+4][0]);
				32'd2: begin
					region_override = script[pc+1][1:0];
				end
				32'd3: page_write(script[pc+1][2:0], script[pc+2][15:0]);
				32'd4: probe_addr(script[pc+1][22:0], script[pc+2][22:0],
				                  script[pc+3][1:0], script[pc+4][0]);
				32'd5: begin
					repeat (script[pc+1]) @(posedge clk_sys);
					#1;
				end
				32'd6: settle_check(script[pc+1][15:0]);
				default: begin
					$display("Unknown command %0h in data file record %0d", cmd, pc/rec_words);
					bad_cmd = 1'b1;
				end
			endcase
			pc += rec_words;
		end

		@(posedge clk_sys);
		#1;
		$display("Checks done: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0 && pass_count > 0 && !bad_cmd) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- test/cart_input.dat
// Columns: cmd op1 op2 op3 op4 (hex). 1 write idx addr data exp_rom_download,
// 2 override val, 3 page sel data, 4 probe va exp_va exp_region exp_cart, 5 wait n, 6 settle run
00000006 0000003F 00000000 00000000 00000000
00000001 00000040 00000000 00000000 00000001
00000001 00000040 000001F0 0000004A 00000001
00000001 00000040 002FFFFE 00001234 00000001
00000004 007FFFFF 0017FFFF 00000000 00000001
00000004 000E5A5A 00065A5A 00000000 00000001
00000001 00000040 00000000 00000000 00000001
00000001 00000040 000001F0 00000055 00000001
00000004 000E5A5A 00000A5A 00000001 00000001
00000005 00000050 00000000 00000000 00000000
00000006 0000003F 00000000 00000000 00000000
00000001 00000040 00000000 00000000 00000001
00000001 00000040 000001F0 00000045 00000001
00000004 00000000 00000000 00000002 00000001
00000005 00000050 00000000 00000000 00000000
00000006 0000003F 00000000 00000000 00000000
00000002 00000001 00000000 00000000 00000000
00000004 00000000 00000000 00000000 00000001
00000005 00000050 00000000 00000000 00000000
00000006 0000003F 00000000 00000000 00000000
00000002 00000002 00000000 00000000 00000000
00000004 00000000 00000000 00000001 00000001
00000005 00000050 00000000 00000000 00000000
00000006 0000003F 00000000 00000000 00000000
00000002 00000003 00000000 00000000 00000000
00000004 00000000 00000000 00000002 00000001
00000005 00000050 00000000 00000000 00000000
00000006 0000003F 00000000 00000000 00000000
00000002 00000000 00000000 00000000 00000000
00000004 00000000 00000000 00000002 00000001
00000001 00000040 00000000 00000000 00000001
00000001 00000040 000001F0 00000045 00000001
00000001 00000040 007FFFFE 00000000 00000001
00000003 00000002 00000009 00000000 00000000
00000004 00081234 00241234 00000002 00000001
00000001 00000040 00000000 00000000 00000001
00000001 00000040 003FFFFE 00000000 00000001
00000003 00000002 00000009 00000000 00000000
00000004 00081234 00081234 00000002 00000001
00000001 00000040 00000000 00000000 00000001
00000001 00000040 007FFFFE 00000000 00000001
00000003 00000002 00000009 00000000 00000000
00000004 00081234 00241234 00000002 00000001
00000001 00000040 00000000 00000000 00000001
00000001 00000040 007FFFFE 00000000 00000001
00000004 00081234 00081234 00000002 00000001
00000001 00000002 00000000 00000000 00000000
00000001 00000002 000001F0 0000004A 00000000
00000004 007FFFFF 001FFFFF 00000002 00000001
00000000 00000000 00000000 00000000 00000000

//--- build.f
+incdir+rtl
rtl/loader_pkg.sv
rtl/cart_map_pkg.sv
rtl/download_tracker.sv
rtl/region_ctrl.sv
rtl/bank_mapper.sv
rtl/cart_loader_top.sv
test/cart_checker.sv
test/tb_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the cartridge loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f build.f --top-module tb_top \
	-o sim_cart > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_cart > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
	echo "No result line in sim.log"
	exit 1
fi
exit 0
